//--- iq_pkg.sv
package iq_pkg;

	// ==============================
	// queue geometry
	// ==============================

	// number of entries in the circular instruction queue
	localparam int QENTRIES = 8;

	// the commit unit retires at most this many of the oldest entries at once
	localparam int QSLOTS = 3;

	// width of an index into the queue
	localparam int QBITS = $clog2(QENTRIES);

	// sequence numbers run from 1 up to QENTRIES, so one more bit than an index
	localparam int SNBITS = $clog2(QENTRIES + 1);

	// a retire count goes from 0 to QSLOTS
	localparam int AMTBITS = $clog2(QSLOTS + 1);

	// ==============================
	// payload and bus widths
	// ==============================

	// one instruction word as it arrives on the dispatch bus
	localparam int PAYLOAD_W = 32;

	// a retire slot carries the payload above its sequence number
	// so the sequence number sits in the low SNBITS bits of the slot
	localparam int SLOT_W = PAYLOAD_W + SNBITS;

	// the retire bus packs all slots side by side, slot 0 in the lowest bits
	localparam int RETIRE_W = QSLOTS * SLOT_W;

endpackage

//--- seqnum.sv
`timescale 1ns/10ps

module seqnum import iq_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic [QBITS-1:0]    heads [QENTRIES],
	input  logic [AMTBITS-1:0]  retire_amt,
	input  logic [QENTRIES-1:0] iq_v,
	input  logic [SNBITS-1:0]   iq_sn [QENTRIES],
	output logic [SNBITS-1:0]   maxsn,
	output logic [SNBITS-1:0]   tosub
);

	// largest sequence number among the valid entries, before renormalization
	logic [SNBITS-1:0] top_sn;

	// walk the oldest heads that are being retired this cycle
	// the last valid one among them sets the amount every survivor drops by
	// with nothing retiring the amount stays zero
	always_comb
	begin
		tosub = '0;
		for (int j = 0; j < QSLOTS; j++)
		begin
			if (j < retire_amt && iq_v[heads[j]])
				tosub = iq_sn[heads[j]];
		end
	end

	// plain search over every entry for the highest valid number
	// a comparator chain, but the queue is only eight deep
	always_comb
	begin
		top_sn = '0;
		for (int n = 0; n < QENTRIES; n++)
		begin
			if (iq_v[n] && iq_sn[n] > top_sn)
				top_sn = iq_sn[n];
		end
	end

	// report the maximum as it will look after this cycle's subtraction
	// so a new entry written in the same cycle lands right above it
	assign maxsn = top_sn - tosub;

endmodule

//--- iq_dispatch.sv
`timescale 1ns/10ps

module iq_dispatch import iq_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 disp_cyc,
	input  logic                 disp_stb,
	input  logic                 disp_we,
	input  logic [PAYLOAD_W-1:0] disp_dat,
	output logic                 disp_ack,
	input  logic                 full,
	output logic                 enq,
	output logic [PAYLOAD_W-1:0] enq_dat
);

	// a write strobe that has not yet been placed in the queue
	logic req;

	// set once the current strobe has been enqueued, held until stb drops
	logic taken;

	// ==============================
	// request decode
	// ==============================

	// a Wishbone write is pending while cyc, stb and we are all up
	// and this strobe has not already produced an entry
	assign req = disp_cyc && disp_stb && disp_we && !taken;

	// the queue takes the word on the next edge, but only if there is room
	// while full stays high the request just waits here with ack withheld
	assign enq = req && !full;

	// the master holds its data stable until ack, so it goes straight across
	assign enq_dat = disp_dat;

	// ==============================
	// handshake registers
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			disp_ack <= 1'b0;
			taken <= 1'b0;
		end
		else
		begin
			// ack rises on the same edge that writes the entry
			// it lasts one cycle since taken blocks a second enqueue
			disp_ack <= enq;

			// remember that this strobe is done, the master keeps stb up
			// through the ack cycle and only drops it after seeing ack
			if (enq)
				taken <= 1'b1;
			else if (!disp_stb)
				taken <= 1'b0;
		end
	end

endmodule

//--- iq_queue.sv
`timescale 1ns/10ps

module iq_queue import iq_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 enq,
	input  logic [PAYLOAD_W-1:0] enq_dat,
	input  logic [AMTBITS-1:0]   retire_amt,
	output logic                 full,
	output logic [QSLOTS-1:0]    head_v,
	output logic [RETIRE_W-1:0]  head_dat,
	output logic [SNBITS-1:0]    maxsn
);

	// ==============================
	// queue storage
	// ==============================

	// one valid bit per entry, the live entries always form one run from head
	logic [QENTRIES-1:0]  iq_v;

	// sequence number of each entry, the oldest live one always holds 1
	logic [SNBITS-1:0]    iq_sn [QENTRIES];

	// instruction word of each entry
	logic [PAYLOAD_W-1:0] iq_dat [QENTRIES];

	// head points at the oldest entry, tail at the next free slot
	logic [QBITS-1:0]     head;
	logic [QBITS-1:0]     tail;

	// entry indices in age order, heads[0] is the oldest
	logic [QBITS-1:0]     heads [QENTRIES];

	// renormalization amount for this cycle, from seqnum
	logic [SNBITS-1:0]    tosub;

	// index arithmetic wraps on its own because the depth is a power of two
	always_comb
	begin
		for (int i = 0; i < QENTRIES; i++)
			heads[i] = head + QBITS'(i);
	end

	seqnum u_seqnum
	(
		.clk        (clk),
		.rst        (rst),
		.heads      (heads),
		.retire_amt (retire_amt),
		.iq_v       (iq_v),
		.iq_sn      (iq_sn),
		.maxsn      (maxsn),
		.tosub      (tosub)
	);

	// the slot under tail is still busy only when the ring has wrapped onto head
	assign full = iq_v[tail];

	// ==============================
	// head window for the commit unit
	// ==============================

	// present the oldest QSLOTS entries, each slot as payload over sequence number
	// valid bits come out contiguous from slot 0 since live entries never have holes
	always_comb
	begin
		for (int k = 0; k < QSLOTS; k++)
		begin
			head_v[k] = iq_v[heads[k]];
			head_dat[k*SLOT_W +: SLOT_W] = {iq_dat[heads[k]], iq_sn[heads[k]]};
		end
	end

	// ==============================
	// pointer and valid update
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			iq_v <= '0;
			head <= '0;
			tail <= '0;
		end
		else
		begin
			// free the retired heads, retire_amt is zero outside the ack cycle
			for (int i = 0; i < QSLOTS; i++)
			begin
				if (i < retire_amt)
					iq_v[heads[i]] <= 1'b0;
			end
			head <= head + QBITS'(retire_amt);

			// enq only comes while the tail slot is free
			// so it never collides with an entry freed above
			if (enq)
			begin
				iq_v[tail] <= 1'b1;
				tail <= tail + 1'b1;
			end
		end
	end

	// ==============================
	// sequence numbers and payloads
	// ==============================

	always_ff @(posedge clk)
	begin
		// lower every live entry by the number of the youngest retired head
		// retired entries go invalid on this edge so their values no longer matter
		for (int n = 0; n < QENTRIES; n++)
		begin
			if (iq_v[n])
				iq_sn[n] <= iq_sn[n] - tosub;
		end

		// maxsn already has tosub taken off, so one above it is the new youngest
		if (enq)
		begin
			iq_sn[tail] <= maxsn + 1'b1;
			iq_dat[tail] <= enq_dat;
		end
	end

endmodule

//--- iq_commit.sv
`timescale 1ns/10ps

module iq_commit import iq_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic [QSLOTS-1:0]   head_v,
	input  logic [RETIRE_W-1:0] head_dat,
	input  logic                ret_ack,
	output logic                ret_cyc,
	output logic                ret_stb,
	output logic                ret_we,
	output logic [QSLOTS-1:0]   ret_sel,
	output logic [RETIRE_W-1:0] ret_dat,
	output logic [AMTBITS-1:0]  retire_amt
);

	// idle waits for a valid head, write holds one group on the bus until ack
	typedef enum logic {st_idle, st_write} state_t;

	state_t state;

	// number of valid slots in the head window right now
	logic [AMTBITS-1:0]  grp_cnt;

	// number of slots in the group currently on the bus
	logic [AMTBITS-1:0]  sel_cnt;

	// head window with the empty slots cleared
	logic [RETIRE_W-1:0] grp_dat;

	// ==============================
	// group build
	// ==============================

	// count the valid heads and blank out the slots that hold nothing
	// an empty slot may carry stale contents from an old entry
	always_comb
	begin
		grp_cnt = '0;
		for (int k = 0; k < QSLOTS; k++)
		begin
			if (head_v[k])
				grp_cnt = grp_cnt + 1'b1;
			grp_dat[k*SLOT_W +: SLOT_W] = head_v[k] ? head_dat[k*SLOT_W +: SLOT_W]
				: {SLOT_W{1'b0}};
		end
	end

	// the queue frees entries only in the ack cycle
	assign retire_amt = (state == st_write && ret_ack) ? sel_cnt : '0;

	// ==============================
	// bus master FSM
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			ret_cyc <= 1'b0;
			ret_stb <= 1'b0;
			ret_we <= 1'b0;
			ret_sel <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					// start a write as soon as the oldest entry is valid
					// the queue updated on the ack edge, so the idle cycle after a
					// group always sees the fresh head window
					if (head_v[0])
					begin
						state <= st_write;
						ret_cyc <= 1'b1;
						ret_stb <= 1'b1;
						ret_we <= 1'b1;
						ret_sel <= head_v;
					end
				end
				st_write:
				begin
					// a stalled sink just leaves the group sitting here
					if (ret_ack)
					begin
						state <= st_idle;
						ret_cyc <= 1'b0;
						ret_stb <= 1'b0;
						ret_we <= 1'b0;
						ret_sel <= '0;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// group contents are captured at the launch edge and stay put until ack
	always_ff @(posedge clk)
	begin
		if (state == st_idle && head_v[0])
		begin
			ret_dat <= grp_dat;
			sel_cnt <= grp_cnt;
		end
	end

endmodule

//--- iq_top.sv
`timescale 1ns/10ps

module iq_top import iq_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	// dispatch bus, Wishbone classic slave
	input  logic                 disp_cyc,
	input  logic                 disp_stb,
	input  logic                 disp_we,
	input  logic [PAYLOAD_W-1:0] disp_dat,
	output logic                 disp_ack,
	// retire bus, Wishbone classic master
	output logic                 ret_cyc,
	output logic                 ret_stb,
	output logic                 ret_we,
	output logic [QSLOTS-1:0]    ret_sel,
	output logic [RETIRE_W-1:0]  ret_dat,
	input  logic                 ret_ack,
	// highest live sequence number, equal to the queue occupancy
	output logic [SNBITS-1:0]    maxsn
);

	// ==============================
	// internal links
	// ==============================

	// dispatch to queue
	logic                 enq;
	logic [PAYLOAD_W-1:0] enq_dat;
	logic                 full;

	// queue to commit and back
	logic [QSLOTS-1:0]    head_v;
	logic [RETIRE_W-1:0]  head_dat;
	logic [AMTBITS-1:0]   retire_amt;

	iq_dispatch u_dispatch
	(
		.clk      (clk),
		.rst      (rst),
		.disp_cyc (disp_cyc),
		.disp_stb (disp_stb),
		.disp_we  (disp_we),
		.disp_dat (disp_dat),
		.disp_ack (disp_ack),
		.full     (full),
		.enq      (enq),
		.enq_dat  (enq_dat)
	);

	iq_queue u_queue
	(
		.clk        (clk),
		.rst        (rst),
		.enq        (enq),
		.enq_dat    (enq_dat),
		.retire_amt (retire_amt),
		.full       (full),
		.head_v     (head_v),
		.head_dat   (head_dat),
		.maxsn      (maxsn)
	);

	iq_commit u_commit
	(
		.clk        (clk),
		.rst        (rst),
		.head_v     (head_v),
		.head_dat   (head_dat),
		.ret_ack    (ret_ack),
		.ret_cyc    (ret_cyc),
		.ret_stb    (ret_stb),
		.ret_we     (ret_we),
		.ret_sel    (ret_sel),
		.ret_dat    (ret_dat),
		.retire_amt (retire_amt)
	);

endmodule

//--- tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen
(
	output logic clk,
	output logic rst
);

	// the clock period is 20 ns, so each phase lasts 10 ns
	localparam int HALF_NS = 10;

	// reset stays up for this many rising edges
	localparam int RST_CYCLES = 10;

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_NS) clk = ~clk;
	end

	// the DUT resets synchronously, so release lines up with an edge
	initial
	begin
		rst <= 1'b1;
		repeat (RST_CYCLES)
			@(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- tb_iq_top.sv
`timescale 1ns/10ps

module tb_iq_top import iq_pkg::*;
();

	// ==============================
	// run length
	// ==============================

	localparam int CLK_NS = 20;
	localparam int STREAM_N = 40;
	// a full queue plus one word that has to wait for room
	localparam int BP_N = QENTRIES + 1;
	localparam int HOLD_CYCLES = 12;
	localparam int MAX_STALL = 3;
	localparam int WAIT_LIMIT = 400;
	// forty cycles per transfer and a margin for reset and the drains
	localparam int WATCHDOG_NS = ((STREAM_N + BP_N) * 40 + 100) * CLK_NS;

	logic                 clk;
	logic                 rst;
	logic                 disp_cyc;
	logic                 disp_stb;
	logic                 disp_we;
	logic [PAYLOAD_W-1:0] disp_dat;
	logic                 disp_ack;
	logic                 ret_cyc;
	logic                 ret_stb;
	logic                 ret_we;
	logic [QSLOTS-1:0]    ret_sel;
	logic [RETIRE_W-1:0]  ret_dat;
	logic                 ret_ack;
	logic [SNBITS-1:0]    maxsn;

	// freezes the retire sink so the queue can fill up
	logic                 sink_hold;

	// words the DUT has accepted and not yet retired, oldest first
	logic [PAYLOAD_W-1:0] exp_q [$];
	int                   accepted = 0;
	int                   retired = 0;
	int                   ret_acks = 0;
	int                   err_cnt = 0;
	int                   tests_run = 0;
	int                   tests_failed = 0;

	tb_clkgen u_clkgen
	(
		.clk (clk),
		.rst (rst)
	);

	iq_top i_iq_top (.*);

	function automatic void report_mismatch(input string msg);
		err_cnt++;
		$display("Mismatch at %0d ns: %s", $time, msg);
	endfunction

	function automatic void flag_error(input string msg);
		err_cnt++;
		$display("Error at %0d ns: %s", $time, msg);
	endfunction

	function automatic void close_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endfunction

	// ==============================
	// scoreboard
	// ==============================

	// slot k of a renormalized group must carry number k+1
	// and the payloads must come out in the order they went in
	function automatic void check_group();
		logic [SLOT_W-1:0]    slot;
		logic [PAYLOAD_W-1:0] want;
		for (int k = 0; k < QSLOTS; k++)
		begin
			if (ret_sel[k])
			begin
				slot = ret_dat[k*SLOT_W +: SLOT_W];
				retired++;
				assert (slot[SNBITS-1:0] == SNBITS'(k + 1))
				else report_mismatch($sformatf("slot %0d has sequence number %0d", k,
					slot[SNBITS-1:0]));
				if (exp_q.size() == 0)
					flag_error("a word was retired that was never dispatched");
				else
				begin
					want = exp_q.pop_front();
					assert (slot[SLOT_W-1:SNBITS] == want)
					else report_mismatch($sformatf("slot %0d payload %h, expected %h", k,
						slot[SLOT_W-1:SNBITS], want));
				end
			end
		end
	endfunction

	always @(posedge clk)
	begin
		if (!rst)
		begin
			// with no ack in flight maxsn must equal the number of live entries
			if (!disp_ack && !ret_ack)
				assert (maxsn == SNBITS'(accepted - retired))
				else report_mismatch($sformatf("maxsn %0d with %0d entries live", maxsn,
					accepted - retired));
			if (disp_ack)
			begin
				exp_q.push_back(disp_dat);
				accepted++;
			end
			if (ret_ack && ret_stb)
			begin
				ret_acks++;
				check_group();
			end
		end
	end

	// ==============================
	// bus rules
	// ==============================

	// the first reset edge clears the outputs and they stay cleared
	a_reset: assert property (@(posedge clk)
		rst |=> !disp_ack && !ret_cyc && !ret_stb && maxsn == '0)
		else flag_error("an output was not cleared during reset");

	// a group waiting for the sink must not move
	a_hold: assert property (@(posedge clk) disable iff (rst)
		ret_stb && !ret_ack |=> ret_stb && $stable(ret_sel) && $stable(ret_dat))
		else report_mismatch("the retire group changed before ret_ack");

	a_gap: assert property (@(posedge clk) disable iff (rst) ret_ack |=> !ret_stb)
		else flag_error("ret_stb stayed high in the cycle after ret_ack");

	a_dpulse: assert property (@(posedge clk) disable iff (rst) disp_ack |=> !disp_ack)
		else flag_error("disp_ack lasted longer than one cycle");

	// slots fill upward from slot 0, so sel plus one has no bit in common with sel
	a_sel: assert property (@(posedge clk) disable iff (rst)
		ret_stb |-> ret_cyc && ret_we && ret_sel != '0 && (ret_sel & (ret_sel + 1'b1)) == '0)
		else flag_error("ret_sel is not a contiguous run from slot 0");

	// ==============================
	// retire sink and watchdog
	// ==============================

	// acks each group after a random stall of up to MAX_STALL cycles
	initial
	begin
		int stall_left;
		stall_left = 0;
		ret_ack <= 1'b0;
		forever
		begin
			@(posedge clk);
			if (rst || ret_ack)
				ret_ack <= 1'b0;
			else if (ret_stb && !sink_hold)
			begin
				if (stall_left == 0)
				begin
					ret_ack <= 1'b1;
					stall_left = int'($urandom % (MAX_STALL + 1));
				end
				else
					stall_left--;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the DUT stopped answering", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	// ==============================
	// dispatch master
	// ==============================

	task automatic raise_write(input logic [PAYLOAD_W-1:0] dat);
		disp_cyc <= 1'b1;
		disp_stb <= 1'b1;
		disp_we <= 1'b1;
		disp_dat <= dat;
	endtask

	// hold the write until ack, then keep stb low for one cycle
	task automatic await_ack();
		int n;
		n = 0;
		@(posedge clk);
		while (!disp_ack && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		assert (disp_ack)
		else flag_error("disp_ack never came for a dispatch write");
		disp_cyc <= 1'b0;
		disp_stb <= 1'b0;
		disp_we <= 1'b0;
		@(posedge clk);
	endtask

	// the sink empties the queue and the scoreboard must run dry with it
	task automatic wait_drained();
		int n;
		n = 0;
		@(negedge clk);
		while ((exp_q.size() != 0 || ret_stb || maxsn != '0) && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		assert (exp_q.size() == 0 && !ret_stb)
		else flag_error("the queue did not drain");
		assert (accepted == retired)
		else report_mismatch($sformatf("%0d words accepted, %0d retired", accepted, retired));
		@(posedge clk);
	endtask

	initial
	begin
		int errs;
		int acks_before;
		void'($urandom(21));
		disp_cyc <= 1'b0;
		disp_stb <= 1'b0;
		disp_we <= 1'b0;
		disp_dat <= '0;
		sink_hold <= 1'b0;

		errs = err_cnt;
		while (rst !== 1'b0)
			@(posedge clk);
		// the last reset check is evaluated on this edge
		@(posedge clk);
		close_test("reset", errs);

		// random words with an idle gap now and then
		errs = err_cnt;
		for (int i = 0; i < STREAM_N; i++)
		begin
			raise_write(PAYLOAD_W'($urandom));
			await_ack();
			repeat ($urandom % 3)
				@(posedge clk);
		end
		wait_drained();
		close_test("stream", errs);

		// with the sink frozen eight words fill the queue and the ninth must wait
		errs = err_cnt;
		sink_hold <= 1'b1;
		for (int i = 0; i < QENTRIES; i++)
		begin
			raise_write(PAYLOAD_W'($urandom));
			await_ack();
		end
		raise_write(PAYLOAD_W'($urandom));
		repeat (HOLD_CYCLES)
		begin
			@(posedge clk);
			assert (!disp_ack)
			else flag_error("disp_ack came while the queue was full");
		end
		acks_before = ret_acks;
		sink_hold <= 1'b0;
		await_ack();
		assert (ret_acks != acks_before)
		else flag_error("dispatch resumed before any group was retired");
		wait_drained();
		close_test("backpressure", errs);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			err_cnt);
		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- iq_top.f
iq_pkg.sv
seqnum.sv
iq_dispatch.sv
iq_queue.sv
iq_commit.sv
iq_top.sv
tb_clkgen.sv
tb_iq_top.sv

//--- Makefile
# Verilator build and run of the instruction queue testbench

VERILATOR ?= verilator
TOP       ?= tb_iq_top
FILELIST  ?= iq_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "make test    build the testbench with Verilator and run it"
	@echo "make clean   remove the Verilator build directory"
	@echo "VERILATOR, TOP, FILELIST, OBJ_DIR and VFLAGS can be set on the command line"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
